//--- design/eth_pkg.sv
package eth_pkg;

   typedef logic [11:0] reg_addr_t;
   typedef logic [7:0]  byte_t;
   typedef logic [3:0]  nibble_t;
   typedef logic [10:0] len_t;
   typedef logic [10:0] buf_addr_t;
   typedef logic [31:0] crc_t;
   typedef logic [31:0] word_t;
   typedef logic [47:0] mac_t;

   // Register map, bit 11 selects the data buffers
   localparam reg_addr_t ADDR_STATUS    = 12'h000;
   localparam reg_addr_t ADDR_SEND      = 12'h001;
   localparam reg_addr_t ADDR_RCVACK    = 12'h002;
   localparam reg_addr_t ADDR_SCRATCH   = 12'h003;
   localparam reg_addr_t ADDR_TX_NBYTES = 12'h004;
   localparam reg_addr_t ADDR_RX_NBYTES = 12'h005;
   localparam reg_addr_t ADDR_CRC       = 12'h006;
   localparam reg_addr_t ADDR_SOFTRST   = 12'h007;

   localparam len_t NBYTES_RESET = 11'd46;

   // Line framing
   localparam int      PREAMBLE_NIBBLES = 15;
   localparam nibble_t PREAMBLE_NIB     = 4'h5;
   localparam nibble_t SFD_NIB          = 4'hD;

   // Reflected CRC-32 and the register value after a good frame
   localparam crc_t CRC_POLY    = 32'hEDB88320;
   localparam crc_t CRC_RESIDUE = 32'hDEBB20E3;

   // One MII nibble, LSB first
   function automatic crc_t crc_step(crc_t crc, nibble_t d);
      crc_t c;
      c = crc;
      for (int i = 0; i < 4; i++) begin
         if (c[0] ^ d[i]) begin
            c = (c >> 1) ^ CRC_POLY;
         end else begin
            c = c >> 1;
         end
      end
      return c;
   endfunction

endpackage

//--- design/eth_buf_ram.sv
module eth_buf_ram #(
   parameter int DEPTH_W = 11
) (
   input  logic               clk,
   input  logic               wr,
   input  eth_pkg::buf_addr_t wr_addr,
   input  eth_pkg::byte_t     wr_data,
   input  eth_pkg::buf_addr_t rd_addr,
   output eth_pkg::byte_t     rd_data
);

   eth_pkg::byte_t mem [0:(1 << DEPTH_W) - 1];

   // One write port, registered read port
   always_ff @(posedge clk) begin
      if (wr) begin
         mem[wr_addr[DEPTH_W-1:0]] <= wr_data;
      end
      rd_data <= mem[rd_addr[DEPTH_W-1:0]];
   end

endmodule

//--- design/eth_regs.sv
module eth_regs #(
   parameter int PHY_RST_CYCLES = 64
) (
   input  logic               clk,
   input  logic               rst_int,
   input  logic               sel,
   input  logic               we,
   input  eth_pkg::reg_addr_t addr,
   input  eth_pkg::word_t     wdata,
   input  eth_pkg::byte_t     rx_rd_data,
   input  logic               tx_busy,
   input  logic               rx_rcvd,
   input  logic               rx_crc_ok,
   input  eth_pkg::len_t      rx_nbytes,
   input  eth_pkg::crc_t      rx_crc,
   output logic               ready,
   output eth_pkg::word_t     rdata,
   output logic               tx_wr,
   output logic               send,
   output logic               rcv_ack,
   output eth_pkg::len_t      tx_nbytes,
   output logic               rst_core,
   output logic               phy_resetn
);

   localparam int CNT_W = (PHY_RST_CYCLES > 1) ? $clog2(PHY_RST_CYCLES) : 1;

   logic              send_en;
   logic              ack_en;
   logic              scratch_en;
   logic              nbytes_en;
   logic              soft_en;
   logic              rst_soft;
   logic              tx_ready;
   logic              rd_buf;
   eth_pkg::word_t    scratch;
   eth_pkg::word_t    rdata_q;
   logic [CNT_W-1:0]  phy_cnt;

   assign rst_core = rst_int | rst_soft;
   assign tx_ready = ~tx_busy & phy_resetn;

   // Write decode
   always_comb begin
      send_en    = 1'b0;
      ack_en     = 1'b0;
      scratch_en = 1'b0;
      nbytes_en  = 1'b0;
      soft_en    = 1'b0;
      tx_wr      = 1'b0;
      if (sel && we) begin
         if (addr[11]) begin
            tx_wr = 1'b1;
         end else begin
            case (addr)
               eth_pkg::ADDR_SEND:      send_en    = 1'b1;
               eth_pkg::ADDR_RCVACK:    ack_en     = 1'b1;
               eth_pkg::ADDR_SCRATCH:   scratch_en = 1'b1;
               eth_pkg::ADDR_TX_NBYTES: nbytes_en  = 1'b1;
               eth_pkg::ADDR_SOFTRST:   soft_en    = 1'b1;
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         ready    <= 1'b0;
         rst_soft <= 1'b0;
      end else begin
         ready    <= sel;
         rst_soft <= soft_en & ~rst_soft;
      end
   end

   // Strobes and CPU-visible registers
   always_ff @(posedge clk or posedge rst_core) begin
      if (rst_core) begin
         send      <= 1'b0;
         rcv_ack   <= 1'b0;
         scratch   <= '0;
         tx_nbytes <= eth_pkg::NBYTES_RESET;
      end else begin
         send    <= send_en & ~send;
         rcv_ack <= ack_en & ~rcv_ack;
         if (scratch_en) begin
            scratch <= wdata;
         end
         if (nbytes_en) begin
            tx_nbytes <= wdata[10:0];
         end
      end
   end

   // Buffer bytes come straight from the RAM read register
   always_ff @(posedge clk) begin
      if (sel) begin
         rd_buf <= addr[11];
         case (addr)
            eth_pkg::ADDR_STATUS:
               rdata_q <= {28'h0, phy_resetn, rx_crc_ok, rx_rcvd, tx_ready};
            eth_pkg::ADDR_SCRATCH:   rdata_q <= scratch;
            eth_pkg::ADDR_TX_NBYTES: rdata_q <= {21'h0, tx_nbytes};
            eth_pkg::ADDR_RX_NBYTES: rdata_q <= {21'h0, rx_nbytes};
            eth_pkg::ADDR_CRC:       rdata_q <= rx_crc;
            default:                 rdata_q <= '0;
         endcase
      end
   end

   assign rdata = rd_buf ? {24'h0, rx_rd_data} : rdata_q;

   // PHY held in reset after power-up
   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         phy_cnt    <= '0;
         phy_resetn <= 1'b0;
      end else if (!phy_resetn) begin
         if (phy_cnt == CNT_W'(PHY_RST_CYCLES - 1)) begin
            phy_resetn <= 1'b1;
         end else begin
            phy_cnt <= phy_cnt + 1'b1;
         end
      end
   end

   a_send_pulse: assert property (@(posedge clk) disable iff (rst_int) send |=> !send);
   a_soft_pulse: assert property (@(posedge clk) disable iff (rst_int) rst_core |=> !rst_core);

endmodule

//--- design/eth_tx.sv
module eth_tx (
   input  logic               clk,
   input  logic               rst_core,
   input  logic               send,
   input  eth_pkg::len_t      nbytes,
   input  eth_pkg::byte_t     rd_data,
   input  logic               phy_resetn,
   output eth_pkg::buf_addr_t rd_addr,
   output logic               tx_busy,
   output logic               tx_en,
   output eth_pkg::nibble_t   tx_data
);

   typedef enum logic [2:0] {
      S_IDLE,
      S_PRE,
      S_SFD,
      S_DLO,
      S_DHI,
      S_CRC
   } state_t;

   state_t         state;
   logic [3:0]     cnt;
   eth_pkg::crc_t  crc;

   always_ff @(posedge clk or posedge rst_core) begin
      if (rst_core) begin
         state   <= S_IDLE;
         cnt     <= '0;
         rd_addr <= '0;
         tx_busy <= 1'b0;
         tx_en   <= 1'b0;
         tx_data <= '0;
      end else begin
         tx_en <= (state != S_IDLE);
         case (state)
            S_IDLE: begin
               // Busy stays up one cycle past the last nibble
               tx_busy <= tx_en;
               if (send && !tx_busy && !tx_en && phy_resetn) begin
                  state   <= S_PRE;
                  tx_busy <= 1'b1;
                  rd_addr <= '0;
                  cnt     <= '0;
               end
            end
            S_PRE: begin
               tx_data <= eth_pkg::PREAMBLE_NIB;
               cnt     <= cnt + 4'd1;
               if (cnt == 4'(eth_pkg::PREAMBLE_NIBBLES - 1)) begin
                  state <= S_SFD;
               end
            end
            S_SFD: begin
               tx_data <= eth_pkg::SFD_NIB;
               state   <= S_DLO;
            end
            S_DLO: begin
               // Next byte is fetched while the high nibble goes out
               tx_data <= rd_data[3:0];
               rd_addr <= rd_addr + 11'd1;
               state   <= S_DHI;
            end
            S_DHI: begin
               tx_data <= rd_data[7:4];
               if (rd_addr == nbytes) begin
                  cnt   <= '0;
                  state <= S_CRC;
               end else begin
                  state <= S_DLO;
               end
            end
            S_CRC: begin
               tx_data <= ~crc[3:0];
               cnt     <= cnt + 4'd1;
               if (cnt == 4'd7) begin
                  state <= S_IDLE;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // FCS accumulated over the payload and shifted out low nibble first
   always_ff @(posedge clk) begin
      case (state)
         S_IDLE:  crc <= '1;
         S_DLO:   crc <= eth_pkg::crc_step(crc, rd_data[3:0]);
         S_DHI:   crc <= eth_pkg::crc_step(crc, rd_data[7:4]);
         S_CRC:   crc <= {4'h0, crc[31:4]};
         default: ;
      endcase
   end

   a_tx_en_busy: assert property (@(posedge clk) disable iff (rst_core)
      tx_en |-> tx_busy);

endmodule

//--- design/eth_rx.sv
module eth_rx #(
   parameter eth_pkg::mac_t MAC_ADDR = 48'h01_60_6E_11_02_0F
) (
   input  logic               clk,
   input  logic               rst_core,
   input  logic               rx_dv,
   input  eth_pkg::nibble_t   rx_data,
   input  logic               rcv_ack,
   output logic               wr,
   output eth_pkg::buf_addr_t wr_addr,
   output eth_pkg::byte_t     wr_data,
   output logic               rx_rcvd,
   output logic               rx_crc_ok,
   output eth_pkg::len_t      rx_nbytes,
   output eth_pkg::crc_t      rx_crc
);

   typedef enum logic [2:0] {
      S_IDLE,
      S_HUNT,
      S_LO,
      S_HI,
      S_DROP,
      S_DONE
   } state_t;

   state_t            state;
   eth_pkg::len_t     byte_cnt;
   eth_pkg::nibble_t  lo_nib;
   eth_pkg::byte_t    rx_byte;
   eth_pkg::crc_t     crc;
   eth_pkg::crc_t     crc_sh;
   eth_pkg::mac_t     mac_sh;
   logic              hit_mac;
   logic              hit_bc;
   logic              hit_mac_n;
   logic              hit_bc_n;
   logic              addr_ok;

   assign rx_byte   = {rx_data, lo_nib};
   assign hit_mac_n = hit_mac & (rx_byte == mac_sh[47:40]);
   assign hit_bc_n  = hit_bc & (rx_byte == 8'hFF);

   always_ff @(posedge clk or posedge rst_core) begin
      if (rst_core) begin
         state     <= S_IDLE;
         byte_cnt  <= '0;
         wr        <= 1'b0;
         hit_mac   <= 1'b0;
         hit_bc    <= 1'b0;
         addr_ok   <= 1'b0;
         rx_rcvd   <= 1'b0;
         rx_crc_ok <= 1'b0;
         rx_nbytes <= eth_pkg::NBYTES_RESET;
         rx_crc    <= '0;
      end else begin
         wr <= 1'b0;
         case (state)
            S_IDLE: begin
               // A pending frame blocks the next one
               if (rx_dv) begin
                  state <= rx_rcvd ? S_DROP : S_HUNT;
               end
            end
            S_HUNT: begin
               if (!rx_dv) begin
                  state <= S_IDLE;
               end else if (rx_data == eth_pkg::SFD_NIB) begin
                  byte_cnt <= '0;
                  hit_mac  <= 1'b1;
                  hit_bc   <= 1'b1;
                  addr_ok  <= 1'b0;
                  state    <= S_LO;
               end
            end
            S_LO: begin
               if (!rx_dv) begin
                  state <= addr_ok ? S_DONE : S_IDLE;
               end else begin
                  state <= S_HI;
               end
            end
            S_HI: begin
               if (!rx_dv) begin
                  state <= addr_ok ? S_DONE : S_IDLE;
               end else begin
                  wr       <= 1'b1;
                  byte_cnt <= byte_cnt + 11'd1;
                  state    <= S_LO;
                  if (byte_cnt < 11'd6) begin
                     hit_mac <= hit_mac_n;
                     hit_bc  <= hit_bc_n;
                  end
                  // Destination complete after the sixth byte
                  if (byte_cnt == 11'd5) begin
                     if (hit_mac_n || hit_bc_n) begin
                        addr_ok <= 1'b1;
                     end else begin
                        state <= S_DROP;
                     end
                  end
               end
            end
            S_DROP: begin
               if (!rx_dv) begin
                  state <= S_IDLE;
               end
            end
            S_DONE: begin
               rx_rcvd   <= 1'b1;
               rx_crc_ok <= (crc == eth_pkg::CRC_RESIDUE);
               rx_nbytes <= byte_cnt - 11'd4;
               rx_crc    <= crc_sh;
               state     <= S_IDLE;
            end
            default: state <= S_IDLE;
         endcase
         if (rcv_ack && state != S_DONE) begin
            rx_rcvd <= 1'b0;
         end
      end
   end

   // Bytes assembled and run through the CRC, the last four kept
   always_ff @(posedge clk) begin
      case (state)
         S_HUNT: begin
            crc    <= '1;
            mac_sh <= MAC_ADDR;
         end
         S_LO: begin
            // Nothing is taken once rx_dv has dropped
            if (rx_dv) begin
               lo_nib <= rx_data;
               crc    <= eth_pkg::crc_step(crc, rx_data);
            end
         end
         S_HI: begin
            if (rx_dv) begin
               crc     <= eth_pkg::crc_step(crc, rx_data);
               wr_addr <= byte_cnt;
               wr_data <= rx_byte;
               crc_sh  <= {rx_byte, crc_sh[31:8]};
               mac_sh  <= {mac_sh[39:0], 8'h00};
            end
         end
         default: ;
      endcase
   end

   a_no_wr_pending: assert property (@(posedge clk) disable iff (rst_core)
      rx_rcvd |-> !wr);

endmodule

//--- design/eth_core.sv
module eth_core #(
   parameter eth_pkg::mac_t MAC_ADDR       = 48'h01_60_6E_11_02_0F,
   parameter int            PHY_RST_CYCLES = 64
) (
   input  logic               clk,
   input  logic               rst_int,
   input  logic               sel,
   input  logic               we,
   input  eth_pkg::reg_addr_t addr,
   input  eth_pkg::word_t     wdata,
   output logic               ready,
   output eth_pkg::word_t     rdata,
   output logic               tx_en,
   output eth_pkg::nibble_t   tx_data,
   input  logic               rx_dv,
   input  eth_pkg::nibble_t   rx_data,
   output logic               phy_resetn
);

   localparam int BUF_DEPTH_W = $bits(eth_pkg::buf_addr_t);

   logic               tx_wr;
   logic               send;
   logic               rcv_ack;
   logic               rst_core;
   logic               tx_busy;
   logic               rx_rcvd;
   logic               rx_crc_ok;
   logic               rx_wr;
   eth_pkg::len_t      tx_nbytes;
   eth_pkg::len_t      rx_nbytes;
   eth_pkg::crc_t      rx_crc;
   eth_pkg::buf_addr_t tx_rd_addr;
   eth_pkg::byte_t     tx_rd_data;
   eth_pkg::buf_addr_t rx_wr_addr;
   eth_pkg::byte_t     rx_wr_data;
   eth_pkg::byte_t     rx_rd_data;

   eth_regs #(
      .PHY_RST_CYCLES(PHY_RST_CYCLES)
   ) i_regs (
      .clk        (clk),
      .rst_int    (rst_int),
      .sel        (sel),
      .we         (we),
      .addr       (addr),
      .wdata      (wdata),
      .rx_rd_data (rx_rd_data),
      .tx_busy    (tx_busy),
      .rx_rcvd    (rx_rcvd),
      .rx_crc_ok  (rx_crc_ok),
      .rx_nbytes  (rx_nbytes),
      .rx_crc     (rx_crc),
      .ready      (ready),
      .rdata      (rdata),
      .tx_wr      (tx_wr),
      .send       (send),
      .rcv_ack    (rcv_ack),
      .tx_nbytes  (tx_nbytes),
      .rst_core   (rst_core),
      .phy_resetn (phy_resetn)
   );

   // Written by the CPU, read by the transmitter
   eth_buf_ram #(.DEPTH_W(BUF_DEPTH_W)) tx_buf (
      .clk     (clk),
      .wr      (tx_wr),
      .wr_addr (addr[10:0]),
      .wr_data (wdata[7:0]),
      .rd_addr (tx_rd_addr),
      .rd_data (tx_rd_data)
   );

   // Written by the receiver, read by the CPU
   eth_buf_ram #(.DEPTH_W(BUF_DEPTH_W)) rx_buf (
      .clk     (clk),
      .wr      (rx_wr),
      .wr_addr (rx_wr_addr),
      .wr_data (rx_wr_data),
      .rd_addr (addr[10:0]),
      .rd_data (rx_rd_data)
   );

   eth_tx i_tx (
      .clk        (clk),
      .rst_core   (rst_core),
      .send       (send),
      .nbytes     (tx_nbytes),
      .rd_data    (tx_rd_data),
      .phy_resetn (phy_resetn),
      .rd_addr    (tx_rd_addr),
      .tx_busy    (tx_busy),
      .tx_en      (tx_en),
      .tx_data    (tx_data)
   );

   eth_rx #(
      .MAC_ADDR(MAC_ADDR)
   ) i_rx (
      .clk       (clk),
      .rst_core  (rst_core),
      .rx_dv     (rx_dv),
      .rx_data   (rx_data),
      .rcv_ack   (rcv_ack),
      .wr        (rx_wr),
      .wr_addr   (rx_wr_addr),
      .wr_data   (rx_wr_data),
      .rx_rcvd   (rx_rcvd),
      .rx_crc_ok (rx_crc_ok),
      .rx_nbytes (rx_nbytes),
      .rx_crc    (rx_crc)
   );

endmodule

//--- dv/eth_tb.sv
module eth_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam eth_pkg::mac_t MAC_ADDR       = 48'h31_32_33_34_35_36;
   localparam int            PHY_RST_CYCLES = 64;
   localparam int            PAT_DEPTH      = 512;
   localparam int            WAIT_LIMIT     = 400;
   localparam int            MAX_RECORDS    = 64;

   logic               clk;
   logic               rst_int;
   logic               sel;
   logic               we;
   eth_pkg::reg_addr_t addr;
   eth_pkg::word_t     wdata;
   logic               ready;
   eth_pkg::word_t     rdata;
   logic               tx_en;
   eth_pkg::nibble_t   tx_data;
   logic               rx_dv;
   eth_pkg::nibble_t   rx_data;
   logic               phy_resetn;

   eth_pkg::byte_t pat [0:PAT_DEPTH-1];
   eth_pkg::byte_t frame [0:255];
   eth_pkg::byte_t fcs [0:3];
   int             kind;
   int             nbytes;
   int             pos;

   eth_core #(
      .MAC_ADDR       (MAC_ADDR),
      .PHY_RST_CYCLES (PHY_RST_CYCLES)
   ) i_dut (
      .clk        (clk),
      .rst_int    (rst_int),
      .sel        (sel),
      .we         (we),
      .addr       (addr),
      .wdata      (wdata),
      .ready      (ready),
      .rdata      (rdata),
      .tx_en      (tx_en),
      .tx_data    (tx_data),
      .rx_dv      (rx_dv),
      .rx_data    (rx_data),
      .phy_resetn (phy_resetn)
   );

   initial clk = 1'b0;
   always #4 clk = ~clk;

   task automatic report_mismatch(input string msg);
      $display("Mismatch at %0t ns: %s", $time, msg);
      $display("Finished with errors");
      $fatal(1, "Value check failed");
   endtask

   task automatic report_failure(input string msg);
      $display("Error at %0t ns: %s", $time, msg);
      $display("Finished with errors");
      $fatal(1, "Run stopped");
   endtask

   // All driving and sampling happens 1 ns after the rising edge
   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   function automatic eth_pkg::reg_addr_t buf_index(input int i);
      return {1'b1, 11'(i)};
   endfunction

   task automatic bus_write(input eth_pkg::reg_addr_t a, input eth_pkg::word_t d);
      sel   = 1'b1;
      we    = 1'b1;
      addr  = a;
      wdata = d;
      next_cycle();
      sel = 1'b0;
      we  = 1'b0;
   endtask

   task automatic bus_read(input eth_pkg::reg_addr_t a, output eth_pkg::word_t d);
      sel  = 1'b1;
      we   = 1'b0;
      addr = a;
      next_cycle();
      assert (ready === 1'b1)
         else report_mismatch($sformatf("ready %b one cycle after read of %h", ready, a));
      d   = rdata;
      sel = 1'b0;
   endtask

   task automatic check_reg(input eth_pkg::reg_addr_t a, input eth_pkg::word_t exp,
                            input string what);
      eth_pkg::word_t d;
      bus_read(a, d);
      assert (d === exp)
         else report_mismatch($sformatf("%s: read %h, expected %h", what, d, exp));
   endtask

   task automatic wait_status(input int bit_idx, input logic val, input string what);
      eth_pkg::word_t st;
      int             n;
      n = 0;
      bus_read(eth_pkg::ADDR_STATUS, st);
      while (st[bit_idx] !== val && n < WAIT_LIMIT) begin
         bus_read(eth_pkg::ADDR_STATUS, st);
         n++;
      end
      assert (st[bit_idx] === val) else report_failure($sformatf("timed out waiting for %s", what));
   endtask

   // Record layout: kind, count, frame bytes, four FCS bytes
   task automatic load_record();
      kind = int'(pat[pos]);
      if (kind != 0) begin
         nbytes = int'(pat[pos+1]);
         for (int i = 0; i < nbytes; i++) begin
            frame[i] = pat[pos+2+i];
         end
         for (int i = 0; i < 4; i++) begin
            fcs[i] = pat[pos+2+nbytes+i];
         end
         pos = pos + 6 + nbytes;
      end
   endtask

   task automatic drive_nibble(input eth_pkg::nibble_t n);
      rx_dv   = 1'b1;
      rx_data = n;
      next_cycle();
   endtask

   task automatic drive_frame(input logic corrupt);
      eth_pkg::byte_t b;
      for (int i = 0; i < 15; i++) begin
         drive_nibble(4'h5);
      end
      drive_nibble(4'hD);
      for (int i = 0; i < nbytes + 4; i++) begin
         b = (i < nbytes) ? frame[i] : fcs[i-nbytes];
         // Last payload byte gets one bit flipped
         if (corrupt && i == nbytes - 1) begin
            b[0] = ~b[0];
         end
         drive_nibble(b[3:0]);
         drive_nibble(b[7:4]);
      end
      rx_dv   = 1'b0;
      rx_data = '0;
   endtask

   task automatic check_transmit();
      eth_pkg::nibble_t exp[$];
      int               n;
      for (int i = 0; i < 15; i++) begin
         exp.push_back(4'h5);
      end
      exp.push_back(4'hD);
      for (int i = 0; i < nbytes; i++) begin
         exp.push_back(frame[i][3:0]);
         exp.push_back(frame[i][7:4]);
      end
      for (int i = 0; i < 4; i++) begin
         exp.push_back(fcs[i][3:0]);
         exp.push_back(fcs[i][7:4]);
      end
      wait_status(0, 1'b1, "tx_ready before send");
      for (int i = 0; i < nbytes; i++) begin
         bus_write(buf_index(i), {24'h0, frame[i]});
      end
      bus_write(eth_pkg::ADDR_TX_NBYTES, 32'(nbytes));
      bus_write(eth_pkg::ADDR_SEND, 32'h1);
      assert (tx_en === 1'b0) else report_mismatch("tx_en high in the send cycle");
      next_cycle();
      assert (tx_en === 1'b0) else report_mismatch("tx_en high one cycle after send");
      next_cycle();
      assert (tx_en === 1'b1) else report_mismatch("tx_en low two cycles after send");
      n = 0;
      while (tx_en === 1'b1 && n < exp.size()) begin
         assert (tx_data === exp[n])
            else report_mismatch($sformatf("tx nibble %0d is %h, expected %h",
                                           n, tx_data, exp[n]));
         n++;
         next_cycle();
      end
      assert (n == exp.size() && tx_en === 1'b0)
         else report_mismatch($sformatf("tx_en lasted %0d+ cycles, expected %0d",
                                        n, exp.size()));
      wait_status(0, 1'b1, "tx_ready after a frame");
   endtask

   task automatic check_accept(input logic corrupt);
      eth_pkg::word_t d;
      drive_frame(corrupt);
      wait_status(1, 1'b1, "rx_rcvd after a frame");
      bus_read(eth_pkg::ADDR_STATUS, d);
      assert (d[2] === ~corrupt)
         else report_mismatch($sformatf("rx_crc_ok %b, corrupt frame %b", d[2], corrupt));
      check_reg(eth_pkg::ADDR_RX_NBYTES, 32'(nbytes), "rx byte count");
      if (!corrupt) begin
         for (int i = 0; i < nbytes; i++) begin
            check_reg(buf_index(i), {24'h0, frame[i]}, $sformatf("rx buffer byte %0d", i));
         end
         check_reg(eth_pkg::ADDR_CRC, {fcs[3], fcs[2], fcs[1], fcs[0]}, "received FCS");
      end
      bus_write(eth_pkg::ADDR_RCVACK, 32'h1);
      wait_status(1, 1'b0, "rx_rcvd clear after ack");
   endtask

   task automatic check_drop();
      eth_pkg::word_t d;
      drive_frame(1'b0);
      for (int i = 0; i < 100; i++) begin
         bus_read(eth_pkg::ADDR_STATUS, d);
         assert (d[1] === 1'b0) else report_mismatch("rx_rcvd set by a foreign frame");
      end
   endtask

   initial begin
      eth_pkg::word_t d;
      int             n;
      int             rec_pos;
      int             first_accept;
      sel     = 1'b0;
      we      = 1'b0;
      addr    = '0;
      wdata   = '0;
      rx_dv   = 1'b0;
      rx_data = '0;
      rst_int = 1'b1;
      pos     = 0;
      kind    = 0;
      nbytes  = 0;
      $readmemh("dv/eth_patterns.hex", pat);
      repeat (8) @(posedge clk);
      #1;
      rst_int = 1'b0;

      n = 0;
      while (phy_resetn !== 1'b1 && n < 2 * PHY_RST_CYCLES) begin
         next_cycle();
         n++;
      end
      assert (phy_resetn === 1'b1) else report_failure("phy_resetn never rose after reset");
      bus_read(eth_pkg::ADDR_STATUS, d);
      assert ({d[3], d[1], d[0]} === 3'b101)
         else report_mismatch($sformatf("status %h after PHY reset", d));
      check_reg(eth_pkg::ADDR_TX_NBYTES, 32'd46, "tx count after reset");
      bus_write(eth_pkg::ADDR_SCRATCH, 32'hA5C3_0F96);
      check_reg(eth_pkg::ADDR_SCRATCH, 32'hA5C3_0F96, "scratch readback");
      next_cycle();
      assert (ready === 1'b0) else report_mismatch("ready high without sel");

      first_accept = -1;
      rec_pos      = pos;
      load_record();
      for (int r = 0; r < MAX_RECORDS && kind != 0; r++) begin
         case (kind)
            1: check_transmit();
            2: begin
               if (first_accept < 0) begin
                  first_accept = rec_pos;
               end
               check_accept(1'b0);
            end
            3: check_drop();
            default: report_failure("unknown record kind in the pattern file");
         endcase
         rec_pos = pos;
         load_record();
      end
      assert (first_accept >= 0) else report_failure("pattern file holds no receive frame");

      pos = first_accept;
      load_record();
      check_accept(1'b1);

      // Soft reset while a frame waits for its ack
      drive_frame(1'b0);
      wait_status(1, 1'b1, "rx_rcvd before soft reset");
      bus_write(eth_pkg::ADDR_SCRATCH, 32'h0000_5A5A);
      bus_write(eth_pkg::ADDR_TX_NBYTES, 32'd9);
      bus_write(eth_pkg::ADDR_SOFTRST, 32'h1);
      bus_read(eth_pkg::ADDR_STATUS, d);
      assert (d[1] === 1'b0) else report_mismatch("rx_rcvd still set after soft reset");
      check_reg(eth_pkg::ADDR_SCRATCH, 32'h0, "scratch after soft reset");
      check_reg(eth_pkg::ADDR_TX_NBYTES, 32'd46, "tx count after soft reset");
      check_reg(eth_pkg::ADDR_RX_NBYTES, 32'd46, "rx count after soft reset");

      $display("Finished with no errors");
      $finish;
   end

endmodule

//--- dv/eth_patterns.hex
// kind, byte count, frame bytes, FCS bytes in line order (low byte first)
// kind 01 transmit, 02 receive accept, 03 receive drop, 00 ends the list
01 09
31 32 33 34 35 36 37 38 39
26 39 F4 CB
01 0E
FF FF FF FF FF FF FF 12 26 BE 00 00 00 00
FF FF FF FF
01 2B
54 68 65 20 71 75 69 63 6B 20 62 72 6F 77 6E 20
66 6F 78 20 6A 75 6D 70 73 20 6F 76 65 72 20 74
68 65 20 6C 61 7A 79 20 64 6F 67
39 A3 4F 41
// Destination equals the MAC address
02 09
31 32 33 34 35 36 37 38 39
26 39 F4 CB
// Broadcast destination
02 0E
FF FF FF FF FF FF FF 12 26 BE 00 00 00 00
FF FF FF FF
// Foreign destinations
03 2B
54 68 65 20 71 75 69 63 6B 20 62 72 6F 77 6E 20
66 6F 78 20 6A 75 6D 70 73 20 6F 76 65 72 20 74
68 65 20 6C 61 7A 79 20 64 6F 67
39 A3 4F 41
03 08
FF FF FF FF 00 00 00 00
FF FF FF FF
00

//--- project.f
design/eth_pkg.sv
design/eth_buf_ram.sv
design/eth_regs.sv
design/eth_tx.sv
design/eth_rx.sv
design/eth_core.sv
dv/eth_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timescale 1ns/1ps --top-module eth_tb -f project.f -o eth_sim
./obj_dir/eth_sim 2>&1 | tee sim.log
if grep -q "Finished with errors" sim.log; then
   echo "Simulation failed"
   exit 1
fi
grep -q "Finished with no errors" sim.log
echo "Simulation passed"
